// File: hw/sp3_rx_pkg.sv
/*
 * Uplink frame layout, lane word sizes and header aligner settings
 * shared by the demux and the lane receivers
 */
`default_nettype none

package sp3_rx_pkg;

   // Data path widths
   localparam int MGT_WORD_W      = 32;   // Transceiver word, both lanes interleaved
   localparam int LANE_WORD_W     = 16;   // One lane after de-interleave
   localparam int FRAME_W         = 64;
   localparam int WORDS_PER_FRAME = 4;    // FRAME_W / LANE_WORD_W
   localparam int USER_W          = 56;

   localparam logic [1:0] FRAME_HEADER = 2'b01;

   //////////////////////////////////////////////////////////////////////
   // Frame fields, bit 63 is first on the line
   //////////////////////////////////////////////////////////////////////
   localparam int HDR_LSB  = 62;          // Header 63:62
   localparam int DATA_MSB = 61;          // User data 61:6
   localparam int DATA_LSB = 6;
   localparam int EC_LSB   = 4;           // EC 5:4
   localparam int IC_LSB   = 2;           // IC 3:2
   localparam int PAR_LSB  = 0;           // Parity 1:0
   // Parity bit 1 covers data 55:28 + EC, bit 0 covers data 27:0 + IC

   // Aligner thresholds, in frames
   localparam int REQ_TRUE_HDR     = 8;   // True headers in a row to lock
   localparam int MAX_FALSE_HDR    = 4;   // False headers in a row to unlock
   localparam int SLIP_WAIT_FRAMES = 4;   // Settle time after a slip

   typedef enum logic [1:0] {
      ALIGN_HUNT,                         // Look at next header
      ALIGN_WAIT,                         // Let a slip settle
      ALIGN_CHECK,                        // Count true headers
      ALIGN_LOCKED
   } align_state_e;

endpackage

`default_nettype wire

// File: hw/sp3_csr_pkg.sv
/*
 * Wishbone register map and bit positions of the receiver CSR block
 */
`default_nettype none

package sp3_csr_pkg;

   localparam int WB_DATA_W  = 32;
   localparam int PERR_CNT_W = 16;        // Per-lane saturating counter

   typedef enum logic [1:0] {
      REG_CTRL   = 2'd0,                  // RW, polarity invert
      REG_SLIP   = 2'd1,                  // WO, manual bit-slip pulses
      REG_STATUS = 2'd2,                  // RO, lane ready flags
      REG_PERR   = 2'd3                   // RO, parity error counts, write clears
   } csr_addr_e;

   // Bit positions inside the registers
   localparam int CTRL_POL_BIT   = 0;
   localparam int SLIP_A_BIT     = 0;
   localparam int SLIP_B_BIT     = 1;
   localparam int STAT_RDY_A_BIT = 0;
   localparam int STAT_RDY_B_BIT = 1;
   localparam int PERR_A_LSB     = 0;     // Lane A count 15:0
   localparam int PERR_B_LSB     = 16;    // Lane B count 31:16

endpackage

`default_nettype wire

// File: hw/uplink_stat_if.sv
/*
 * Lane status bundle from one uplink lane to the register block
 */
`default_nettype none

interface uplink_stat_if;

   logic rdy;            // Lane aligner locked
   logic frame_strobe;   // One cycle per delivered frame
   logic parity_err;     // Only meaningful with frame_strobe
   logic hdr_err;        // False header seen while locked

   modport lane (
      output rdy, frame_strobe, parity_err, hdr_err
   );

   modport csr (
      input  rdy, frame_strobe, parity_err, hdr_err
   );

endinterface

`default_nettype wire

// File: hw/sp3_demux.sv
/*
 * Transceiver word demux: polarity invert, even/odd bit split into
 * lanes A and B, and a per-lane sliding window for bit slip
 */
`default_nettype none

module sp3_demux (
   input  logic                               MGT_RXCLK,
   input  logic                               rst_i,
   input  logic [sp3_rx_pkg::MGT_WORD_W-1:0]  mgt_word_i,
   input  logic                               polarity_inv_i,
   input  logic                               slip_a_i,       // From lane A aligner
   input  logic                               slip_b_i,
   input  logic                               csr_slip_a_i,   // Manual pulse from CSR
   input  logic                               csr_slip_b_i,
   output logic [sp3_rx_pkg::LANE_WORD_W-1:0] word_a_o,
   output logic [sp3_rx_pkg::LANE_WORD_W-1:0] word_b_o,
   output logic                               valid_a_o,
   output logic                               valid_b_o
);
   import sp3_rx_pkg::*;

   logic [MGT_WORD_W-1:0]    mgt_word;            // After polarity
   logic [LANE_WORD_W-1:0]   split_a, split_b;    // Current de-interleaved words
   logic [LANE_WORD_W-1:0]   prev_a, prev_b;      // Previous words
   logic [2*LANE_WORD_W-1:0] hist_a, hist_b;      // Older word in the upper half
   logic [$clog2(LANE_WORD_W)-1:0] off_a, off_b;  // Window offsets
   logic                     slip_a, slip_b;

   assign mgt_word = polarity_inv_i ? ~mgt_word_i : mgt_word_i;

   // Bit 2k to lane A, bit 2k+1 to lane B
   always_comb begin
      for (int k = 0; k < LANE_WORD_W; k++) begin
         split_a[k] = mgt_word[2*k];
         split_b[k] = mgt_word[2*k+1];
      end
   end

   assign hist_a = {prev_a, split_a};
   assign hist_b = {prev_b, split_b};

   assign slip_a = slip_a_i | csr_slip_a_i;
   assign slip_b = slip_b_i | csr_slip_b_i;

   // Window moves one bit deeper into the history per slip
   always_ff @(posedge MGT_RXCLK) begin
      prev_a   <= split_a;
      prev_b   <= split_b;
      word_a_o <= hist_a[LANE_WORD_W-1+off_a -: LANE_WORD_W];
      word_b_o <= hist_b[LANE_WORD_W-1+off_b -: LANE_WORD_W];
   end

   always_ff @(posedge MGT_RXCLK) begin
      if (rst_i) begin
         off_a     <= '0;
         off_b     <= '0;
         valid_a_o <= 1'b0;
         valid_b_o <= 1'b0;
      end else begin
         // Offset wrap drops one word so the lane slot stays put
         valid_a_o <= !(slip_a && (&off_a));
         valid_b_o <= !(slip_b && (&off_b));
         if (slip_a)
            off_a <= off_a + 1'b1;
         if (slip_b)
            off_b <= off_b + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hw/uplink_lane.sv
/*
 * One uplink lane: frame assembly from lane words, header aligner FSM
 * with slip requests, and parity check of delivered frames
 */
`default_nettype none

module uplink_lane (
   input  logic                               MGT_RXCLK,
   input  logic                               rst_i,
   input  logic [sp3_rx_pkg::LANE_WORD_W-1:0] word_i,
   input  logic                               valid_i,
   output logic                               slip_o,        // One-cycle request to demux
   output logic [sp3_rx_pkg::USER_W-1:0]      user_data_o,
   output logic [1:0]                         ec_o,
   output logic [1:0]                         ic_o,
   uplink_stat_if.lane                        stat
);
   import sp3_rx_pkg::*;

   align_state_e                          state;
   logic [FRAME_W-LANE_WORD_W-1:0]        frame_sr;      // First three words of a frame
   logic [FRAME_W-1:0]                    frame;         // Frame with the current word
   logic [$clog2(WORDS_PER_FRAME)-1:0]    slot;          // Word position in frame
   logic                                  boundary;      // Last word of a frame
   logic                                  hdr_ok;
   logic                                  lock_nxt;      // Locked after this frame
   logic [USER_W-1:0]                     user_w;
   logic [1:0]                            ec_w, ic_w, par_calc;
   logic [3:0]                            true_cnt;
   logic [2:0]                            false_cnt;
   logic [2:0]                            wait_cnt;

   //////////////////////////////////////////////////////////////////////
   // Frame assembly and field extraction
   //////////////////////////////////////////////////////////////////////
   assign frame    = {frame_sr, word_i};
   assign boundary = valid_i && (slot == WORDS_PER_FRAME-1);
   assign hdr_ok   = (frame[HDR_LSB+1:HDR_LSB] == FRAME_HEADER);

   assign user_w = frame[DATA_MSB:DATA_LSB];
   assign ec_w   = frame[EC_LSB+1:EC_LSB];
   assign ic_w   = frame[IC_LSB+1:IC_LSB];

   assign par_calc[1] = ^{user_w[USER_W-1:USER_W/2], ec_w};   // Upper data half + EC
   assign par_calc[0] = ^{user_w[USER_W/2-1:0], ic_w};        // Lower data half + IC

   assign stat.rdy = (state == ALIGN_LOCKED);

   // Lock state that follows the header of this frame
   always_comb begin
      case (state)
         ALIGN_LOCKED:
            lock_nxt = hdr_ok || (false_cnt != MAX_FALSE_HDR-1);
         ALIGN_HUNT, ALIGN_CHECK:
            lock_nxt = hdr_ok && (true_cnt == REQ_TRUE_HDR-1);
         default:
            lock_nxt = 1'b0;
      endcase
   end

   always_ff @(posedge MGT_RXCLK) begin
      if (valid_i)
         frame_sr <= frame[FRAME_W-LANE_WORD_W-1:0];
      if (boundary && lock_nxt) begin      // Hold last delivered frame
         user_data_o <= user_w;
         ec_o        <= ec_w;
         ic_o        <= ic_w;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Header aligner, acts once per frame boundary
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge MGT_RXCLK) begin
      if (rst_i) begin
         state             <= ALIGN_HUNT;
         slot              <= '0;
         true_cnt          <= '0;
         false_cnt         <= '0;
         wait_cnt          <= '0;
         slip_o            <= 1'b0;
         stat.frame_strobe <= 1'b0;
         stat.parity_err   <= 1'b0;
         stat.hdr_err      <= 1'b0;
      end else begin
         slip_o            <= 1'b0;
         stat.hdr_err      <= 1'b0;
         stat.frame_strobe <= boundary && lock_nxt;
         stat.parity_err   <= boundary && lock_nxt && (par_calc != frame[PAR_LSB+1:PAR_LSB]);
         if (valid_i)
            slot <= slot + 1'b1;
         if (boundary) begin
            case (state)
               ALIGN_HUNT, ALIGN_CHECK: begin
                  if (hdr_ok) begin
                     true_cnt  <= true_cnt + 1'b1;
                     false_cnt <= '0;
                     state     <= lock_nxt ? ALIGN_LOCKED : ALIGN_CHECK;
                  end else begin            // Wrong phase, slip and settle
                     slip_o   <= 1'b1;
                     true_cnt <= '0;
                     wait_cnt <= '0;
                     state    <= ALIGN_WAIT;
                  end
               end
               ALIGN_WAIT: begin
                  wait_cnt <= wait_cnt + 1'b1;
                  if (wait_cnt == SLIP_WAIT_FRAMES-1)
                     state <= ALIGN_HUNT;
               end
               ALIGN_LOCKED: begin
                  if (hdr_ok) begin
                     false_cnt <= '0;
                  end else begin
                     false_cnt    <= false_cnt + 1'b1;
                     stat.hdr_err <= 1'b1;
                     if (!lock_nxt) begin   // Too many in a row
                        true_cnt <= '0;
                        state    <= ALIGN_HUNT;
                     end
                  end
               end
               default: state <= ALIGN_HUNT;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/rx_csr_wb.sv
/*
 * Wishbone classic register block: polarity control, manual slip
 * pulses, lane ready status and saturating parity error counters
 */
`default_nettype none

module rx_csr_wb (
   input  logic                               MGT_RXCLK,
   input  logic                               rst_i,
   input  logic                               wb_cyc_i,
   input  logic                               wb_stb_i,
   input  logic                               wb_we_i,
   input  sp3_csr_pkg::csr_addr_e             wb_adr_i,
   input  logic [sp3_csr_pkg::WB_DATA_W-1:0]  wb_dat_i,
   output logic [sp3_csr_pkg::WB_DATA_W-1:0]  wb_dat_o,
   output logic                               wb_ack_o,
   output logic                               polarity_inv_o,
   output logic                               csr_slip_a_o,
   output logic                               csr_slip_b_o,
   uplink_stat_if.csr                         stat_a,
   uplink_stat_if.csr                         stat_b
);
   import sp3_csr_pkg::*;

   logic                  ack_done;        // Ack given, wait for stb low
   logic                  wr_en;           // Write strobe on the ack cycle
   logic                  pol_q = 1'b0;    // Polarity invert control
   logic [PERR_CNT_W-1:0] perr_a, perr_b;

   function automatic logic [PERR_CNT_W-1:0] perr_inc(
      input logic [PERR_CNT_W-1:0] cnt,
      input logic                  hit
   );
      perr_inc = (hit && !(&cnt)) ? cnt + 1'b1 : cnt;   // Stick at all ones
   endfunction

   assign wr_en          = wb_ack_o && wb_cyc_i && wb_stb_i && wb_we_i;
   assign polarity_inv_o = pol_q;

   // Slip pulses last exactly the ack cycle
   assign csr_slip_a_o = wr_en && (wb_adr_i == REG_SLIP) && wb_dat_i[SLIP_A_BIT];
   assign csr_slip_b_o = wr_en && (wb_adr_i == REG_SLIP) && wb_dat_i[SLIP_B_BIT];

   //////////////////////////////////////////////////////////////////////
   // Bus handshake, one ack per strobe
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge MGT_RXCLK) begin
      if (rst_i) begin
         wb_ack_o <= 1'b0;
         ack_done <= 1'b0;
      end else begin
         wb_ack_o <= wb_cyc_i && wb_stb_i && !wb_ack_o && !ack_done;
         ack_done <= wb_stb_i && (ack_done || wb_ack_o);
      end
   end

   always_ff @(posedge MGT_RXCLK) begin
      if (wr_en && (wb_adr_i == REG_CTRL))
         pol_q <= wb_dat_i[CTRL_POL_BIT];
   end

   // Error counters, any REG_PERR write clears both
   always_ff @(posedge MGT_RXCLK) begin
      if (rst_i || (wr_en && (wb_adr_i == REG_PERR))) begin
         perr_a <= '0;
         perr_b <= '0;
      end else begin
         perr_a <= perr_inc(perr_a, stat_a.frame_strobe && stat_a.parity_err);
         perr_b <= perr_inc(perr_b, stat_b.frame_strobe && stat_b.parity_err);
      end
   end

   // Read mux, sampled by the master with ack
   always_comb begin
      wb_dat_o = '0;
      case (wb_adr_i)
         REG_CTRL:   wb_dat_o[CTRL_POL_BIT] = pol_q;
         REG_STATUS: begin
            wb_dat_o[STAT_RDY_A_BIT] = stat_a.rdy;
            wb_dat_o[STAT_RDY_B_BIT] = stat_b.rdy;
         end
         REG_PERR: begin
            wb_dat_o[PERR_A_LSB +: PERR_CNT_W] = perr_a;
            wb_dat_o[PERR_B_LSB +: PERR_CNT_W] = perr_b;
         end
         default:    wb_dat_o = '0;       // REG_SLIP is write only
      endcase
   end

endmodule

`default_nettype wire

// File: hw/sp3_dual_rx.sv
/*
 * Dual-lane uplink receiver top: demux, lanes A and B, CSR block
 */
`default_nettype none

module sp3_dual_rx (
   input  logic                               MGT_RXCLK,
   input  logic                               rst_i,
   input  logic [sp3_rx_pkg::MGT_WORD_W-1:0]  mgt_word_i,    // Interleaved transceiver word
   // Wishbone classic slave
   input  logic                               wb_cyc_i,
   input  logic                               wb_stb_i,
   input  logic                               wb_we_i,
   input  sp3_csr_pkg::csr_addr_e             wb_adr_i,
   input  logic [sp3_csr_pkg::WB_DATA_W-1:0]  wb_dat_i,
   output logic [sp3_csr_pkg::WB_DATA_W-1:0]  wb_dat_o,
   output logic                               wb_ack_o,
   // Lane A
   output logic [sp3_rx_pkg::USER_W-1:0]      user_data_a_o,
   output logic [1:0]                         ec_a_o,
   output logic [1:0]                         ic_a_o,
   output logic                               strobe_a_o,
   output logic                               rdy_a_o,
   output logic                               parity_err_a_o,
   // Lane B
   output logic [sp3_rx_pkg::USER_W-1:0]      user_data_b_o,
   output logic [1:0]                         ec_b_o,
   output logic [1:0]                         ic_b_o,
   output logic                               strobe_b_o,
   output logic                               rdy_b_o,
   output logic                               parity_err_b_o
);
   import sp3_rx_pkg::*;

   logic [LANE_WORD_W-1:0] word_a, word_b;      // Demux to lanes
   logic                   valid_a, valid_b;
   logic                   slip_a, slip_b;      // Aligner requests back to demux
   logic                   polarity_inv;
   logic                   csr_slip_a, csr_slip_b;

   uplink_stat_if stat_a ();
   uplink_stat_if stat_b ();

   //////////////////////////////////////////////////////////////////////
   // Demux, lanes and register block
   //////////////////////////////////////////////////////////////////////
   sp3_demux demux (
      .MGT_RXCLK      (MGT_RXCLK),
      .rst_i          (rst_i),
      .mgt_word_i     (mgt_word_i),
      .polarity_inv_i (polarity_inv),
      .slip_a_i       (slip_a),
      .slip_b_i       (slip_b),
      .csr_slip_a_i   (csr_slip_a),
      .csr_slip_b_i   (csr_slip_b),
      .word_a_o       (word_a),
      .word_b_o       (word_b),
      .valid_a_o      (valid_a),
      .valid_b_o      (valid_b)
   );

   uplink_lane lane_a (
      .MGT_RXCLK   (MGT_RXCLK),
      .rst_i       (rst_i),
      .word_i      (word_a),
      .valid_i     (valid_a),
      .slip_o      (slip_a),
      .user_data_o (user_data_a_o),
      .ec_o        (ec_a_o),
      .ic_o        (ic_a_o),
      .stat        (stat_a.lane)
   );

   uplink_lane lane_b (
      .MGT_RXCLK   (MGT_RXCLK),
      .rst_i       (rst_i),
      .word_i      (word_b),
      .valid_i     (valid_b),
      .slip_o      (slip_b),
      .user_data_o (user_data_b_o),
      .ec_o        (ec_b_o),
      .ic_o        (ic_b_o),
      .stat        (stat_b.lane)
   );

   rx_csr_wb csr (
      .MGT_RXCLK      (MGT_RXCLK),
      .rst_i          (rst_i),
      .wb_cyc_i       (wb_cyc_i),
      .wb_stb_i       (wb_stb_i),
      .wb_we_i        (wb_we_i),
      .wb_adr_i       (wb_adr_i),
      .wb_dat_i       (wb_dat_i),
      .wb_dat_o       (wb_dat_o),
      .wb_ack_o       (wb_ack_o),
      .polarity_inv_o (polarity_inv),
      .csr_slip_a_o   (csr_slip_a),
      .csr_slip_b_o   (csr_slip_b),
      .stat_a         (stat_a.csr),
      .stat_b         (stat_b.csr)
   );

   // Lane status out to the pins
   assign strobe_a_o     = stat_a.frame_strobe;
   assign rdy_a_o        = stat_a.rdy;
   assign parity_err_a_o = stat_a.parity_err;
   assign strobe_b_o     = stat_b.frame_strobe;
   assign rdy_b_o        = stat_b.rdy;
   assign parity_err_b_o = stat_b.parity_err;

endmodule

`default_nettype wire

// File: verification/sp3_dual_rx_sva.sv
/*
 * Concurrent assertions on the receiver top: Wishbone ack width,
 * strobes and header errors only while ready, slips only while unlocked
 */
`default_nettype none

module sp3_dual_rx_sva (
   input wire logic MGT_RXCLK,
   input wire logic rst_i,
   input wire logic ack_i,        // wb_ack_o of the DUT
   input wire logic strobe_a_i,
   input wire logic strobe_b_i,
   input wire logic rdy_a_i,
   input wire logic rdy_b_i,
   input wire logic slip_a_i,     // Aligner requests, not CSR pulses
   input wire logic slip_b_i,
   input wire logic hdr_err_a_i,  // False header flags of the lanes
   input wire logic hdr_err_b_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // Single cycle ack per strobe
   ack_one_cycle: assert property (@(posedge MGT_RXCLK) disable iff (rst_i)
      ack_i |=> !ack_i)
      else $error("wb_ack_o held longer than one cycle");

   strobe_a_rdy: assert property (@(posedge MGT_RXCLK) disable iff (rst_i)
      strobe_a_i |-> rdy_a_i)
      else $error("lane A strobe while not ready");
   strobe_b_rdy: assert property (@(posedge MGT_RXCLK) disable iff (rst_i)
      strobe_b_i |-> rdy_b_i)
      else $error("lane B strobe while not ready");

   // Aligner may only slip while hunting
   slip_a_unlocked: assert property (@(posedge MGT_RXCLK) disable iff (rst_i)
      slip_a_i |-> !rdy_a_i)
      else $error("lane A slip while locked");
   slip_b_unlocked: assert property (@(posedge MGT_RXCLK) disable iff (rst_i)
      slip_b_i |-> !rdy_b_i)
      else $error("lane B slip while locked");

   // False header flag follows a frame seen in lock
   hdr_err_a_locked: assert property (@(posedge MGT_RXCLK) disable iff (rst_i)
      hdr_err_a_i |-> $past(rdy_a_i))
      else $error("lane A header error while not locked");
   hdr_err_b_locked: assert property (@(posedge MGT_RXCLK) disable iff (rst_i)
      hdr_err_b_i |-> $past(rdy_b_i))
      else $error("lane B header error while not locked");

endmodule

bind sp3_dual_rx sp3_dual_rx_sva sva (
   .MGT_RXCLK   (MGT_RXCLK),
   .rst_i       (rst_i),
   .ack_i       (wb_ack_o),
   .strobe_a_i  (strobe_a_o),
   .strobe_b_i  (strobe_b_o),
   .rdy_a_i     (rdy_a_o),
   .rdy_b_i     (rdy_b_o),
   .slip_a_i    (slip_a),
   .slip_b_i    (slip_b),
   .hdr_err_a_i (stat_a.hdr_err),
   .hdr_err_b_i (stat_b.hdr_err)
);

`default_nettype wire

// File: verification/sp3_dual_rx_tb.sv
/*
 * Receiver testbench: random frame source with serializer and lane
 * interleave, frame history model, Wishbone master and result checks
 */
`default_nettype none

module sp3_dual_rx_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import sp3_rx_pkg::*;
   import sp3_csr_pkg::*;

   // Full hunt for each of four lock events
   localparam int LOCK_CYCLES = 64 * (SLIP_WAIT_FRAMES + 1) * WORDS_PER_FRAME * 4;
   localparam int TRAFFIC     = 3000;                     // Data phases plus bus cycles
   localparam int MAX_CYCLES  = LOCK_CYCLES + TRAFFIC;

   logic                 MGT_RXCLK, rst_i;
   logic [MGT_WORD_W-1:0] mgt_word_i;
   logic                 wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
   csr_addr_e            wb_adr_i;
   logic [WB_DATA_W-1:0] wb_dat_i, wb_dat_o;
   logic [USER_W-1:0]    user_data_a_o, user_data_b_o;
   logic [1:0]           ec_a_o, ic_a_o, ec_b_o, ic_b_o;
   logic                 strobe_a_o, rdy_a_o, parity_err_a_o;
   logic                 strobe_b_o, rdy_b_o, parity_err_b_o;

   // Source model, index 0 is lane A
   logic [FRAME_W-1:0] cur_frame [2];
   logic               cur_err [2];                  // Current frame has bad parity
   int                 pos [2];                      // Next bit to send, 63 first
   logic [FRAME_W:0]   hist [2][256];                // {bad parity, frame} ring
   int                 sent_cnt [2], exp_idx [2], checked [2], err_seen [2];
   logic               synced [2], chk_en [2], inject [2];
   int                 bad_hdr [2];                  // Frames left with a false header
   logic               invert;
   int                 cycles;

   sp3_dual_rx UUT (.*);

   initial begin
      MGT_RXCLK = 1'b0;
      forever #50 MGT_RXCLK = ~MGT_RXCLK;
   end

   //////////////////////////////////////////////////////////////////////
   // Failure reporting and compare tasks
   //////////////////////////////////////////////////////////////////////
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic fail_now(input string msg);
      abort_run($sformatf("Fail at %0t ns: %s", $time, msg));
   endtask

   task automatic check_frame(input int l, input logic [USER_W-1:0] got_d, exp_d,
                              input logic [1:0] got_ec, exp_ec, got_ic, exp_ic);
      if (got_d !== exp_d || got_ec !== exp_ec || got_ic !== exp_ic)
         fail_now($sformatf("lane %0d frame data %h ec %b ic %b, expected %h %b %b",
                            l, got_d, got_ec, got_ic, exp_d, exp_ec, exp_ic));
   endtask

   task automatic check_reg(input string name, input logic [WB_DATA_W-1:0] got, exp);
      if (got !== exp)
         fail_now($sformatf("%s read %h, expected %h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, exp);
      if (got !== exp)
         fail_now($sformatf("%s is %b, expected %b", name, got, exp));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Frame source and serializer
   //////////////////////////////////////////////////////////////////////
   task automatic new_frame(input int l);
      logic [USER_W-1:0] d;
      logic [1:0]        ec, ic, par, hdr;
      logic              bad;
      d      = {24'($urandom), $urandom};
      ec     = 2'($urandom);
      ic     = 2'($urandom);
      par[1] = (^d[55:28]) ^ (^ec);                // Upper half and EC
      par[0] = (^d[27:0]) ^ (^ic);                 // Lower half and IC
      bad    = inject[l] && ($urandom_range(3, 0) == 0);
      if (bad)
         par = par ^ (2'b01 << $urandom_range(1, 0));
      hdr = 2'b01;
      if (bad_hdr[l] > 0) begin
         hdr = 2'b10;
         bad_hdr[l]--;
      end
      cur_frame[l] = {hdr, d, ec, ic, par};
      cur_err[l]   = bad;
   endtask

   task automatic next_bit(input int l, output logic b);
      b = cur_frame[l][pos[l]];
      if (pos[l] == 0) begin                       // Frame fully sent
         hist[l][sent_cnt[l] & 255] = {cur_err[l], cur_frame[l]};
         sent_cnt[l]++;
         new_frame(l);
         pos[l] = FRAME_W - 1;
      end else begin
         pos[l]--;
      end
   endtask

   // Lane word bit 15 is first in time, lane A on even bits
   always @(posedge MGT_RXCLK) begin
      logic [LANE_WORD_W-1:0] la, lb;
      logic [MGT_WORD_W-1:0]  w;
      for (int k = LANE_WORD_W - 1; k >= 0; k--) begin
         next_bit(0, la[k]);
         next_bit(1, lb[k]);
      end
      for (int k = 0; k < LANE_WORD_W; k++) begin
         w[2*k]   = la[k];
         w[2*k+1] = lb[k];
      end
      mgt_word_i <= invert ? ~w : w;
   end

   //////////////////////////////////////////////////////////////////////
   // Output checker, sampled at the falling edge
   //////////////////////////////////////////////////////////////////////
   task automatic check_lane(input int l, input logic stb, rdy, perr,
                             input logic [USER_W-1:0] d, input logic [1:0] ec, ic);
      logic [FRAME_W:0] e;
      if (!rdy) begin                              // Resync at next lock
         synced[l] = 1'b0;
         chk_en[l] = 1'b1;
      end
      if (!stb) begin
         check_flag("parity_err without strobe", perr, 1'b0);
      end else if (chk_en[l]) begin
         if (!synced[l]) begin
            for (int k = sent_cnt[l] - 1; k >= sent_cnt[l] - 4 && k >= 0; k--) begin
               e = hist[l][k & 255];
               if (!synced[l] && e[DATA_MSB:DATA_LSB] == d && e[5:4] == ec && e[3:2] == ic) begin
                  exp_idx[l] = k;
                  synced[l]  = 1'b1;
               end
            end
            if (!synced[l])
               abort_run($sformatf("Lane %0d first frame after lock matches no sent frame", l));
         end
         e = hist[l][exp_idx[l] & 255];
         check_frame(l, d, e[DATA_MSB:DATA_LSB], ec, e[5:4], ic, e[3:2]);
         check_flag("parity_err on strobe", perr, e[FRAME_W]);
         if (e[FRAME_W])
            err_seen[l]++;
         exp_idx[l]++;
         checked[l]++;
      end
   endtask

   always @(negedge MGT_RXCLK) begin
      check_lane(0, strobe_a_o, rdy_a_o, parity_err_a_o, user_data_a_o, ec_a_o, ic_a_o);
      check_lane(1, strobe_b_o, rdy_b_o, parity_err_b_o, user_data_b_o, ec_b_o, ic_b_o);
   end

   always @(posedge MGT_RXCLK) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
         abort_run($sformatf("Timeout, run did not finish in %0d cycles", MAX_CYCLES));
   end

   //////////////////////////////////////////////////////////////////////
   // Wishbone master and sequence helpers
   //////////////////////////////////////////////////////////////////////
   task automatic wb_cycle(input logic we, input csr_addr_e adr,
                           input logic [WB_DATA_W-1:0] wdat, output logic [WB_DATA_W-1:0] rdat);
      @(posedge MGT_RXCLK);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= wdat;
      do @(negedge MGT_RXCLK); while (!wb_ack_o);  // Wait for the slave ack
      rdat = wb_dat_o;
      @(posedge MGT_RXCLK);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
      @(posedge MGT_RXCLK);
   endtask

   task automatic wait_lock();
      do @(negedge MGT_RXCLK); while (!(rdy_a_o && rdy_b_o));
   endtask

   task automatic run_traffic(input int n);
      int a0, b0;
      a0 = checked[0];
      b0 = checked[1];
      repeat (n) @(negedge MGT_RXCLK);
      check_flag("lane A delivered frames", checked[0] - a0 > n / 8, 1'b1);
      check_flag("lane B delivered frames", checked[1] - b0 > n / 8, 1'b1);
   endtask

   initial begin
      logic [WB_DATA_W-1:0] rd;
      void'($urandom(32'hf485814a));
      rst_i    = 1'b1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_adr_i = REG_CTRL;
      wb_dat_i = '0;
      mgt_word_i = '0;
      invert   = 1'b0;
      cycles   = 0;
      for (int l = 0; l < 2; l++) begin
         {sent_cnt[l], exp_idx[l], checked[l], err_seen[l], bad_hdr[l]} = '0;
         {synced[l], chk_en[l], inject[l]} = 3'b010;
         new_frame(l);
         pos[l] = $urandom_range(FRAME_W - 1, 0);  // Random start offset per lane
      end
      repeat (2) @(posedge MGT_RXCLK);
      rst_i <= 1'b0;

      // Lock and data
      wait_lock();
      wb_cycle(1'b0, REG_STATUS, '0, rd);
      check_reg("REG_STATUS", rd, 32'd3);
      run_traffic(200);

      // Parity errors and counters
      wb_cycle(1'b1, REG_PERR, '0, rd);
      @(negedge MGT_RXCLK);
      err_seen = '{0, 0};
      inject   = '{1'b1, 1'b1};
      run_traffic(300);
      inject = '{1'b0, 1'b0};
      repeat (20) @(negedge MGT_RXCLK);
      check_flag("errors injected on both lanes", err_seen[0] > 0 && err_seen[1] > 0, 1'b1);
      wb_cycle(1'b0, REG_PERR, '0, rd);
      check_reg("REG_PERR", rd, {err_seen[1][15:0], err_seen[0][15:0]});
      wb_cycle(1'b1, REG_PERR, '0, rd);
      wb_cycle(1'b0, REG_PERR, '0, rd);
      check_reg("REG_PERR after clear", rd, '0);

      // Polarity, register survives rst_i
      @(negedge MGT_RXCLK);
      chk_en = '{1'b0, 1'b0};
      wb_cycle(1'b1, REG_CTRL, 32'd1, rd);
      @(negedge MGT_RXCLK);
      invert = 1'b1;
      @(posedge MGT_RXCLK);
      rst_i <= 1'b1;
      repeat (2) @(posedge MGT_RXCLK);
      rst_i <= 1'b0;
      wait_lock();
      wb_cycle(1'b0, REG_CTRL, '0, rd);
      check_reg("REG_CTRL", rd, 32'd1);
      run_traffic(200);

      // Lane B false headers, lane A stays up
      @(negedge MGT_RXCLK);
      bad_hdr[1] = MAX_FALSE_HDR;
      do @(negedge MGT_RXCLK); while (rdy_b_o);
      check_flag("rdy_a_o during lane B loss", rdy_a_o, 1'b1);
      wait_lock();

      // Manual slip on lane A
      @(negedge MGT_RXCLK);
      chk_en[0] = 1'b0;                            // Misaligned frames until unlock
      wb_cycle(1'b1, REG_SLIP, 32'd1, rd);
      do @(negedge MGT_RXCLK); while (rdy_a_o);
      check_flag("rdy_b_o during lane A slip", rdy_b_o, 1'b1);
      wait_lock();
      run_traffic(200);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
hw/sp3_rx_pkg.sv
hw/sp3_csr_pkg.sv
hw/uplink_stat_if.sv
hw/sp3_demux.sv
hw/uplink_lane.sv
hw/rx_csr_wb.sv
hw/sp3_dual_rx.sv
verification/sp3_dual_rx_sva.sv
verification/sp3_dual_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the Verilator model of the testbench, run it, then grep the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module sp3_dual_rx_tb \
   -f vlog.f -o sim_bin > build.log 2>&1 &&
./obj_dir/sim_bin > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log and build.log"; exit 1; }
